// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_gba_io
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

# the run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)

// File: rtl/gba_io_pkg.sv
// shared constants for the console IO glue
// addresses are full 28-bit bus addresses and compared word aligned
// io_word_t half 0 is the low halfword, half 1 the high halfword

package gba_io_pkg;

    //////////////////////////////////////////////////
    // bus widths
    //////////////////////////////////////////////////

    localparam int BUS_ADDR_W = 28;
    localparam int BUS_DATA_W = 32;

    // one 32-bit register word, seen whole or as two halfwords
    typedef union packed {
        logic [31:0]      word;
        logic [1:0][15:0] half;   // [0] lo, [1] hi
    } io_word_t;

    //////////////////////////////////////////////////
    // access size codes
    //////////////////////////////////////////////////

    localparam logic [1:0] ACC_BYTE = 2'd0;
    localparam logic [1:0] ACC_HALF = 2'd1;
    localparam logic [1:0] ACC_WORD = 2'd2;

    //////////////////////////////////////////////////
    // register offsets
    //////////////////////////////////////////////////

    localparam logic [BUS_ADDR_W-1:0] ADDR_KEYINPUT = 28'h4000130;  // keycnt at +2
    localparam logic [BUS_ADDR_W-1:0] ADDR_IE       = 28'h4000200;  // IF at +2
    localparam logic [BUS_ADDR_W-1:0] ADDR_IME      = 28'h4000208;
    localparam logic [BUS_ADDR_W-1:0] ADDR_HALTCNT  = 28'h4000300;  // byte at +1

    //////////////////////////////////////////////////
    // interrupt bit positions in IE / IF
    //////////////////////////////////////////////////

    localparam logic [3:0] IRQ_VBLANK  = 4'd0;
    localparam logic [3:0] IRQ_HBLANK  = 4'd1;
    localparam logic [3:0] IRQ_LCDSTAT = 4'd2;
    localparam logic [3:0] IRQ_TIMER0  = 4'd3;   // timers 0..3 on bits 3..6
    localparam logic [3:0] IRQ_SERIAL  = 4'd7;
    localparam logic [3:0] IRQ_DMA0    = 4'd8;   // dma 0..3 on bits 8..11
    localparam logic [3:0] IRQ_KEYPAD  = 4'd12;

    // console keys in keyinput
    localparam int NUM_KEYS = 10;

endpackage

// File: rtl/gba_io_top.sv
// IO glue around the CPU bus: reset sequencer, bus decoder, keypad, interrupts
// gba_on is the synchronous reset of everything after the sequencer
// bus requests are dropped while gba_on is low
`timescale 1ns/1ps

module gba_io_top
    import gba_io_pkg::*;
#(
    parameter int RESET_CYCLES = 16
) (
    input  logic                  clk16,
    input  logic                  resetn,
    input  logic [11:0]           joy_btns,
    input  logic                  irq_vblank,
    input  logic                  irq_hblank,
    input  logic                  irq_lcdstat,
    input  logic [3:0]            irq_timer,
    input  logic                  irq_serial,
    input  logic [3:0]            irq_dma,
    input  logic [BUS_ADDR_W-1:0] bus_addr,
    input  logic [BUS_DATA_W-1:0] bus_dout,
    input  logic                  bus_rnw,
    input  logic                  bus_ena,
    input  logic [1:0]            bus_acc,
    output logic [BUS_DATA_W-1:0] bus_din,
    output logic                  bus_done,
    output logic                  gba_on,
    output logic                  cpu_irq,
    output logic                  halt
);

    logic [3:0]  wr_lanes;
    io_word_t    wr_data;
    logic        keycnt_we, ie_we, if_we, ime_we, haltcnt_we;
    logic [15:0] keyinput, keycnt;
    logic [15:0] ie, iflags;
    logic        ime;
    logic        keypad_irq;

    //////////////////////////////////////////////////
    // reset and bus
    //////////////////////////////////////////////////

    reset_sequencer #(.RESET_CYCLES(RESET_CYCLES)) u_reset (
        .clk16(clk16), .resetn(resetn), .gba_on(gba_on)
    );

    io_bus_decoder u_decoder (
        .clk16(clk16), .gba_on(gba_on),
        .bus_addr(bus_addr), .bus_dout(bus_dout), .bus_rnw(bus_rnw),
        .bus_ena(bus_ena), .bus_acc(bus_acc),
        .keyinput(keyinput), .keycnt(keycnt), .ie(ie), .iflags(iflags), .ime(ime),
        .bus_din(bus_din), .bus_done(bus_done),
        .wr_lanes(wr_lanes), .wr_data(wr_data),
        .keycnt_we(keycnt_we), .ie_we(ie_we), .if_we(if_we),
        .ime_we(ime_we), .haltcnt_we(haltcnt_we)
    );

    //////////////////////////////////////////////////
    // register blocks
    //////////////////////////////////////////////////

    keypad u_keypad (
        .clk16(clk16), .gba_on(gba_on), .joy_btns(joy_btns),
        .keycnt_we(keycnt_we), .wr_lanes(wr_lanes), .wr_data(wr_data),
        .keyinput(keyinput), .keycnt(keycnt), .keypad_irq(keypad_irq)
    );

    interrupt_controller u_intc (
        .clk16(clk16), .gba_on(gba_on),
        .irq_vblank(irq_vblank), .irq_hblank(irq_hblank), .irq_lcdstat(irq_lcdstat),
        .irq_timer(irq_timer), .irq_serial(irq_serial), .irq_dma(irq_dma),
        .keypad_irq(keypad_irq),
        .ie_we(ie_we), .if_we(if_we), .ime_we(ime_we), .haltcnt_we(haltcnt_we),
        .wr_lanes(wr_lanes), .wr_data(wr_data),
        .ie(ie), .iflags(iflags), .ime(ime), .cpu_irq(cpu_irq), .halt(halt)
    );

endmodule

// File: rtl/interrupt_controller.sv
// IE, IF, IME and halt; no stop mode
// interrupt inputs are one-cycle pulses, a level would set IF every cycle
// an IF bit hit by a pulse and a clear in the same cycle stays set
`timescale 1ns/1ps

module interrupt_controller
    import gba_io_pkg::*;
(
    input  logic        clk16,
    input  logic        gba_on,
    input  logic        irq_vblank,
    input  logic        irq_hblank,
    input  logic        irq_lcdstat,
    input  logic [3:0]  irq_timer,
    input  logic        irq_serial,
    input  logic [3:0]  irq_dma,
    input  logic        keypad_irq,
    input  logic        ie_we,
    input  logic        if_we,
    input  logic        ime_we,
    input  logic        haltcnt_we,
    input  logic [3:0]  wr_lanes,
    input  io_word_t    wr_data,
    output logic [15:0] ie,
    output logic [15:0] iflags,
    output logic        ime,
    output logic        cpu_irq,
    output logic        halt
);

    logic [15:0] irq_src;
    logic [15:0] if_clr;
    logic        pending;
    logic        halt_req;

    //////////////////////////////////////////////////
    // sources onto their IF bits
    //////////////////////////////////////////////////

    always_comb begin
        irq_src                  = '0;
        irq_src[IRQ_VBLANK]      = irq_vblank;
        irq_src[IRQ_HBLANK]      = irq_hblank;
        irq_src[IRQ_LCDSTAT]     = irq_lcdstat;
        irq_src[IRQ_TIMER0 +: 4] = irq_timer;
        irq_src[IRQ_SERIAL]      = irq_serial;
        irq_src[IRQ_DMA0 +: 4]   = irq_dma;
        irq_src[IRQ_KEYPAD]      = keypad_irq;
    end

    // write one to clear, only on the lanes written
    assign if_clr = if_we ? ({{8{wr_lanes[3]}}, {8{wr_lanes[2]}}} & wr_data.half[1])
                          : 16'h0000;

    assign pending  = |(ie & iflags);
    assign cpu_irq  = ime & pending;
    assign halt_req = haltcnt_we & ~wr_data.word[15];   // bit 7 of byte 1, clear means halt

    //////////////////////////////////////////////////
    // registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            ie     <= '0;
            iflags <= '0;
            ime    <= 1'b0;
            halt   <= 1'b0;
        end else begin
            if (ie_we && wr_lanes[0])
                ie[7:0] <= wr_data.half[0][7:0];
            if (ie_we && wr_lanes[1])
                ie[15:8] <= wr_data.half[0][15:8];

            iflags <= (iflags & ~if_clr) | irq_src;   // pulse wins over clear

            if (ime_we)
                ime <= wr_data.word[0];

            // wakeup ignores IME
            if (pending)
                halt <= 1'b0;
            else if (halt_req)
                halt <= 1'b1;
        end
    end

    a_halt_wakes: assert property (
        @(posedge clk16) disable iff (!gba_on) (halt && pending) |=> !halt)
        else $error("halt held with an enabled interrupt pending");

endmodule

// File: rtl/io_bus_decoder.sv
// IO register bus, one cycle from bus_ena to bus_done, no back-pressure
// write data must already sit on its byte lanes, nothing is shifted
// unmapped reads give zero, unmapped writes complete and are dropped
`timescale 1ns/1ps

module io_bus_decoder
    import gba_io_pkg::*;
(
    input  logic                  clk16,
    input  logic                  gba_on,
    input  logic [BUS_ADDR_W-1:0] bus_addr,
    input  logic [BUS_DATA_W-1:0] bus_dout,
    input  logic                  bus_rnw,
    input  logic                  bus_ena,
    input  logic [1:0]            bus_acc,
    input  logic [15:0]           keyinput,
    input  logic [15:0]           keycnt,
    input  logic [15:0]           ie,
    input  logic [15:0]           iflags,
    input  logic                  ime,
    output logic [BUS_DATA_W-1:0] bus_din,
    output logic                  bus_done,
    output logic [3:0]            wr_lanes,
    output io_word_t              wr_data,
    output logic                  keycnt_we,
    output logic                  ie_we,
    output logic                  if_we,
    output logic                  ime_we,
    output logic                  haltcnt_we
);

    logic [BUS_ADDR_W-1:0] word_addr;
    logic [3:0]            lanes;
    logic                  wr_req;
    logic [BUS_ADDR_W-1:0] req_addr;   // word address of the access in flight
    logic                  req_rnw;
    io_word_t              rd_word;

    assign word_addr = {bus_addr[BUS_ADDR_W-1:2], 2'b00};
    assign wr_req    = bus_ena & ~bus_rnw;

    //////////////////////////////////////////////////
    // byte lanes from size and low address bits
    //////////////////////////////////////////////////

    always_comb begin
        case (bus_acc)
            ACC_BYTE: lanes = 4'b0001 << bus_addr[1:0];
            ACC_HALF: lanes = bus_addr[1] ? 4'b1100 : 4'b0011;
            ACC_WORD: lanes = 4'b1111;
            default:  lanes = 4'b0000;   // undefined size, touches nothing
        endcase
    end

    //////////////////////////////////////////////////
    // request capture and write strobes
    //////////////////////////////////////////////////

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            bus_done   <= 1'b0;
            keycnt_we  <= 1'b0;
            ie_we      <= 1'b0;
            if_we      <= 1'b0;
            ime_we     <= 1'b0;
            haltcnt_we <= 1'b0;
        end else begin
            bus_done   <= bus_ena;
            // strobe only when a lane of that register is hit
            keycnt_we  <= wr_req && word_addr == ADDR_KEYINPUT && |lanes[3:2];
            ie_we      <= wr_req && word_addr == ADDR_IE && |lanes[1:0];
            if_we      <= wr_req && word_addr == ADDR_IE && |lanes[3:2];
            ime_we     <= wr_req && word_addr == ADDR_IME && lanes[0];
            haltcnt_we <= wr_req && word_addr == ADDR_HALTCNT && lanes[1];
        end
    end

    always_ff @(posedge clk16) begin
        if (bus_ena) begin
            req_addr     <= word_addr;
            req_rnw      <= bus_rnw;
            wr_lanes     <= lanes;
            wr_data.word <= bus_dout;
        end
    end

    //////////////////////////////////////////////////
    // read mux, valid in the done cycle
    //////////////////////////////////////////////////

    always_comb begin
        rd_word.word = '0;
        if (bus_done && req_rnw) begin
            case (req_addr)
                ADDR_KEYINPUT: begin
                    rd_word.half[0] = keyinput;
                    rd_word.half[1] = keycnt;
                end
                ADDR_IE: begin
                    rd_word.half[0] = ie;
                    rd_word.half[1] = iflags;
                end
                ADDR_IME: rd_word.word[0] = ime;
                default:  rd_word.word = '0;   // haltcnt is write only here
            endcase
        end
    end

    assign bus_din = rd_word.word;

    a_done_follows: assert property (
        @(posedge clk16) disable iff (!gba_on) bus_ena |=> bus_done)
        else $error("bus_done missing after bus_ena");

    // IE and IF share one word, so they count as one target
    a_one_target: assert property (
        @(posedge clk16) disable iff (!gba_on)
        $onehot0({keycnt_we, ie_we | if_we, ime_we, haltcnt_we}))
        else $error("write strobes to two registers at once");

endmodule

// File: rtl/keypad.sv
// keypad registers: keyinput is active low, bits 10..15 read zero
// keycnt bits 10..13 are not stored and read zero
// the button word is sampled with no debounce
`timescale 1ns/1ps

module keypad
    import gba_io_pkg::*;
(
    input  logic        clk16,
    input  logic        gba_on,
    input  logic [11:0] joy_btns,
    input  logic        keycnt_we,
    input  logic [3:0]  wr_lanes,
    input  io_word_t    wr_data,
    output logic [15:0] keyinput,
    output logic [15:0] keycnt,
    output logic        keypad_irq
);

    // controller bit of each console key
    localparam logic [3:0] BTN_B      = 4'd0;
    localparam logic [3:0] BTN_SELECT = 4'd2;
    localparam logic [3:0] BTN_START  = 4'd3;
    localparam logic [3:0] BTN_UP     = 4'd4;
    localparam logic [3:0] BTN_DOWN   = 4'd5;
    localparam logic [3:0] BTN_LEFT   = 4'd6;
    localparam logic [3:0] BTN_RIGHT  = 4'd7;
    localparam logic [3:0] BTN_A      = 4'd8;
    localparam logic [3:0] BTN_L      = 4'd10;
    localparam logic [3:0] BTN_R      = 4'd11;

    logic [11:0]         btn_q;
    logic [NUM_KEYS-1:0] keys;      // pressed, active high
    logic [NUM_KEYS-1:0] sel_keys;
    logic                irq_cond;
    logic                irq_cond_q;

    always_ff @(posedge clk16)
        btn_q <= joy_btns;

    // console order: A B select start right left up down R L
    assign keys = {btn_q[BTN_L], btn_q[BTN_R], btn_q[BTN_DOWN], btn_q[BTN_UP],
                   btn_q[BTN_LEFT], btn_q[BTN_RIGHT], btn_q[BTN_START],
                   btn_q[BTN_SELECT], btn_q[BTN_B], btn_q[BTN_A]};

    assign keyinput = {{(16-NUM_KEYS){1'b0}}, ~keys};

    //////////////////////////////////////////////////
    // keycnt and interrupt condition
    //////////////////////////////////////////////////

    assign sel_keys = keycnt[NUM_KEYS-1:0];

    always_comb begin
        if (keycnt[15])   // AND mode, every selected key down
            irq_cond = keycnt[14] && sel_keys != '0 && (keys & sel_keys) == sel_keys;
        else
            irq_cond = keycnt[14] && |(keys & sel_keys);
    end

    always_ff @(posedge clk16) begin
        if (!gba_on) begin
            keycnt     <= '0;
            irq_cond_q <= 1'b0;
            keypad_irq <= 1'b0;
        end else begin
            if (keycnt_we && wr_lanes[2])
                keycnt[7:0] <= wr_data.half[1][7:0];
            if (keycnt_we && wr_lanes[3]) begin
                keycnt[9:8]   <= wr_data.half[1][9:8];
                keycnt[15:14] <= wr_data.half[1][15:14];
            end
            irq_cond_q <= irq_cond;
            keypad_irq <= irq_cond & ~irq_cond_q;   // rising edge only
        end
    end

    a_irq_pulse: assert property (
        @(posedge clk16) disable iff (!gba_on) keypad_irq |=> !keypad_irq)
        else $error("keypad_irq longer than one cycle");

endmodule

// File: rtl/reset_sequencer.sv
// holds the console off for RESET_CYCLES clk16 cycles after resetn goes high
// resetn is sampled synchronously, no filtering of short pulses
`timescale 1ns/1ps

module reset_sequencer #(
    parameter int RESET_CYCLES = 16
) (
    input  logic clk16,
    input  logic resetn,
    output logic gba_on
);

    localparam int CNT_W = $clog2(RESET_CYCLES + 1);

    logic [CNT_W-1:0] cnt;

    always_ff @(posedge clk16) begin
        if (!resetn) begin
            cnt    <= CNT_W'(RESET_CYCLES);   // reload while held
            gba_on <= 1'b0;
        end else begin
            if (cnt != '0)
                cnt <= cnt - 1'b1;
            gba_on <= (cnt == '0);   // one edge after the count runs out
        end
    end

    // console must be off the cycle after any low resetn
    a_off_in_reset: assert property (@(posedge clk16) !resetn |=> !gba_on)
        else $error("gba_on high after resetn low");

endmodule

// File: sim.f
rtl/gba_io_pkg.sv
rtl/reset_sequencer.sv
rtl/io_bus_decoder.sv
rtl/keypad.sv
rtl/interrupt_controller.sv
rtl/gba_io_top.sv
test/tb_gba_io.sv

// File: test/tb_gba_io.sv
// testbench for the console IO glue, RESET_CYCLES fixed at 16
// inputs change on the rising edge, outputs are sampled on the falling edge
`timescale 1ns/1ps

module tb_gba_io
    import gba_io_pkg::*;
();

    localparam int RESET_CYCLES = 16;
    localparam int WAIT_LIMIT   = 50;
    localparam int SIG_IRQ      = 1;   // selectors for wait_level
    localparam int SIG_HALT     = 2;
    localparam int SIG_DONE     = 3;
    localparam int SRC_VBLANK   = 0;
    localparam int SRC_TIMER2   = 1;

    logic                  clk16, resetn;
    logic [11:0]           joy_btns;
    logic                  irq_vblank, irq_hblank, irq_lcdstat, irq_serial;
    logic [3:0]            irq_timer, irq_dma;
    logic [BUS_ADDR_W-1:0] bus_addr;
    logic [BUS_DATA_W-1:0] bus_dout, bus_din;
    logic                  bus_rnw, bus_ena, bus_done;
    logic [1:0]            bus_acc;
    logic                  gba_on, cpu_irq, halt;

    int          errors    = 0;
    int          timeouts  = 0;
    logic [31:0] rng_state = 32'h1b23;

    gba_io_top #(.RESET_CYCLES(RESET_CYCLES)) UUT (.*);

    initial begin
        clk16 = 1'b0;
        forever #20 clk16 = ~clk16;
    end

    //////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////

    task automatic record_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t ns: %s", $time, msg);
    endtask

    task automatic expect_true(input logic ok, input string msg);
        assert (ok) else record_error(msg);
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state * 32'd1103515245 + 32'd12345;
        return rng_state;
    endfunction

    // controller bit behind each console key
    function automatic int key_source(input int key);
        case (key)
            0: return 8;    // A
            1: return 0;    // B
            2: return 2;    // select
            3: return 3;    // start
            4: return 7;    // right
            5: return 6;    // left
            6: return 4;    // up
            7: return 5;    // down
            8: return 11;   // R
            default: return 10;   // L
        endcase
    endfunction

    function automatic logic [15:0] expected_keyinput(input logic [11:0] btns);
        logic [15:0] value;
        value = 16'h0000;
        for (int k = 0; k < NUM_KEYS; k++)
            value[k] = ~btns[key_source(k)];   // pressed reads as 0
        return value;
    endfunction

    function automatic logic watched(input int sel);
        case (sel)
            SIG_IRQ:    return cpu_irq;
            SIG_HALT:   return halt;
            default:    return bus_done;
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string what);
        int waited;
        waited = 0;
        @(negedge clk16);
        while (watched(sel) !== level && waited < WAIT_LIMIT) begin
            @(negedge clk16);
            waited++;
        end
        if (watched(sel) !== level) begin
            timeouts++;
            $display("timeout: %s did not reach %0b in %0d cycles", what, level, WAIT_LIMIT);
        end
    endtask

    task automatic bus_access(input logic [27:0] addr, input logic [1:0] acc,
                              input logic rnw, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        @(posedge clk16);
        bus_addr <= addr;
        bus_acc  <= acc;
        bus_rnw  <= rnw;
        bus_dout <= wdata;
        bus_ena  <= 1'b1;
        @(posedge clk16);
        bus_ena <= 1'b0;
        wait_level(SIG_DONE, 1'b1, "bus_done");
        rdata = bus_din;   // valid in the done cycle
    endtask

    task automatic bus_write(input logic [27:0] addr, input logic [1:0] acc,
                             input logic [31:0] data);
        logic [31:0] ignored;
        bus_access(addr, acc, 1'b0, data, ignored);
    endtask

    task automatic bus_read(input logic [27:0] addr, input logic [1:0] acc,
                            output logic [31:0] data);
        bus_access(addr, acc, 1'b1, 32'h0, data);
    endtask

    task automatic pulse_source(input int src);
        @(posedge clk16);
        if (src == SRC_VBLANK)
            irq_vblank <= 1'b1;
        else
            irq_timer <= 4'b0100;
        @(posedge clk16);
        irq_vblank <= 1'b0;
        irq_timer  <= 4'b0000;
    endtask

    task automatic set_buttons(input logic [11:0] btns);
        @(posedge clk16);
        joy_btns <= btns;
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk16);
    endtask

    //////////////////////////////////////////////////
    // bus and reset properties
    //////////////////////////////////////////////////

    assert property (@(posedge clk16) disable iff (!gba_on) bus_ena |=> bus_done)
        else record_error("bus_done missing one cycle after bus_ena");
    assert property (@(posedge clk16) disable iff (!gba_on) bus_done |-> $past(bus_ena))
        else record_error("bus_done without a request one cycle before");
    assert property (@(posedge clk16) disable iff (!resetn)
                     !gba_on |-> (!bus_done && !cpu_irq && !halt))
        else record_error("output active while the console is off");

    initial begin
        logic [31:0] rd, r, wdata;
        logic [15:0] ie_model, keys;
        logic        lo_hit, hi_hit;
        logic [27:0] addr;
        logic [1:0]  acc;
        int          cycles;

        resetn      = 1'b0;
        joy_btns    = 12'h000;
        irq_vblank  = 1'b0;
        irq_hblank  = 1'b0;
        irq_lcdstat = 1'b0;
        irq_serial  = 1'b0;
        irq_timer   = 4'h0;
        irq_dma     = 4'h0;
        bus_addr    = '0;
        bus_dout    = '0;
        bus_rnw     = 1'b1;
        bus_ena     = 1'b0;
        bus_acc     = ACC_WORD;
        repeat (4) @(posedge clk16);
        resetn <= 1'b1;

        // release: count cycles from the first edge with resetn high
        @(posedge clk16);
        cycles = 0;
        @(negedge clk16);
        while (!gba_on && cycles < 4 * RESET_CYCLES) begin
            @(negedge clk16);
            cycles++;
        end
        if (!gba_on) begin
            timeouts++;
            $display("timeout: gba_on never rose after reset");
        end
        expect_true(cycles == RESET_CYCLES, $sformatf("gba_on after %0d cycles", cycles));

        bus_write(28'h4000104, ACC_WORD, next_random());
        bus_read(28'h4000104, ACC_WORD, rd);
        expect_true(rd == 32'h0, $sformatf("unmapped read gave %h", rd));

        // keyinput against random buttons
        for (int i = 0; i < 8; i++) begin
            r = next_random();
            set_buttons(r[11:0]);
            keys = expected_keyinput(r[11:0]);
            bus_read(ADDR_KEYINPUT, ACC_HALF, rd);
            expect_true(rd[15:0] == keys, $sformatf("keyinput %h expected %h", rd[15:0], keys));
            bus_read(ADDR_KEYINPUT + 28'd1, ACC_BYTE, rd);
            expect_true(rd[15:8] == keys[15:8], $sformatf("keyinput byte 1 %h", rd[15:8]));
        end

        //////////////////////////////////////////////////
        // byte lanes on IE
        //////////////////////////////////////////////////
        ie_model = 16'h0000;
        for (int i = 0; i < 16; i++) begin
            r     = next_random();
            wdata = next_random();
            case (r[1:0])
                2'd0: begin
                    acc    = ACC_BYTE;
                    addr   = ADDR_IE | 28'(r[3:2]);
                    lo_hit = (r[3:2] == 2'd0);   // bytes 0 and 1 hold IE
                    hi_hit = (r[3:2] == 2'd1);
                end
                2'd1: begin
                    acc    = ACC_HALF;
                    addr   = ADDR_IE | {26'd0, r[2], 1'b0};
                    lo_hit = !r[2];   // upper half is IF
                    hi_hit = !r[2];
                end
                default: begin
                    acc    = ACC_WORD;
                    addr   = ADDR_IE;
                    lo_hit = 1'b1;
                    hi_hit = 1'b1;
                end
            endcase
            bus_write(addr, acc, wdata);
            if (lo_hit)
                ie_model[7:0] = wdata[7:0];
            if (hi_hit)
                ie_model[15:8] = wdata[15:8];
            bus_read(ADDR_IE, ACC_WORD, rd);
            expect_true(rd[15:0] == ie_model, $sformatf("IE %h expected %h", rd[15:0], ie_model));
        end
        bus_write(ADDR_IE + 28'd2, ACC_HALF, 32'hFFFF_FFFF);   // IF half only
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(rd[15:0] == ie_model, "IE changed by a write to the IF half");

        // timer 2 interrupt, IE bit 5
        bus_write(ADDR_IE, ACC_WORD, 32'hFFFF_0020);
        bus_write(ADDR_IME, ACC_WORD, 32'h1);
        pulse_source(SRC_TIMER2);
        wait_level(SIG_IRQ, 1'b1, "cpu_irq");
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(rd[16 + int'(IRQ_TIMER0) + 2], "IF timer 2 bit not set");
        bus_write(ADDR_IE + 28'd2, ACC_HALF, 32'h0020_0000);   // write one to clear
        wait_level(SIG_IRQ, 1'b0, "cpu_irq");
        bus_write(ADDR_IME, ACC_WORD, 32'h0);
        pulse_source(SRC_TIMER2);
        idle_cycles(3);
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(rd[16 + int'(IRQ_TIMER0) + 2], "IF timer 2 bit not set with IME clear");
        expect_true(!cpu_irq, "cpu_irq high with IME clear");

        // halt, woken by vblank with IME still clear
        bus_write(ADDR_IE, ACC_WORD, 32'hFFFF_0001);
        bus_write(ADDR_HALTCNT + 28'd1, ACC_BYTE, 32'h0);
        wait_level(SIG_HALT, 1'b1, "halt");
        idle_cycles(2);
        expect_true(halt, "halt dropped with nothing pending");
        pulse_source(SRC_VBLANK);
        wait_level(SIG_HALT, 1'b0, "halt");
        expect_true(!cpu_irq, "cpu_irq high on wakeup with IME clear");

        //////////////////////////////////////////////////
        // keypad interrupt, AND then OR on A and B
        //////////////////////////////////////////////////
        set_buttons(12'h000);
        bus_write(ADDR_IE, ACC_WORD, 32'hFFFF_0000);
        bus_write(ADDR_KEYINPUT + 28'd2, ACC_HALF, 32'hC003_0000);
        set_buttons(12'h100);   // A only
        idle_cycles(4);
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(!rd[16 + int'(IRQ_KEYPAD)], "keypad IF set with only A in AND mode");
        set_buttons(12'h101);   // A and B
        idle_cycles(4);
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(rd[16 + int'(IRQ_KEYPAD)], "keypad IF not set with A and B in AND mode");

        set_buttons(12'h000);
        idle_cycles(2);
        bus_write(ADDR_IE + 28'd2, ACC_HALF, 32'h1000_0000);
        bus_write(ADDR_KEYINPUT + 28'd2, ACC_HALF, 32'h4003_0000);
        set_buttons(12'h001);   // B only
        idle_cycles(4);
        bus_read(ADDR_IE, ACC_WORD, rd);
        expect_true(rd[16 + int'(IRQ_KEYPAD)], "keypad IF not set with B in OR mode");

        idle_cycles(2);
        $display("check errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0)
            $display("ALL CHECKS PASSED");
        else
            $display("CHECKS FAILED");
        $finish;
    end

endmodule
